/* compile.f */
+incdir+hdl
hdl/pipeCtrlPkg.sv
hdl/instrDecode.sv
hdl/stageTrack.sv
hdl/divTimer.sv
hdl/hazard.sv
hdl/pipeCtrl.sv
testbench/clockGen.sv
testbench/tbPipeCtrl.sv

/* hdl/divTimer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pipeCtrl_settings.svh"

module divTimer (
    input  wire  clk,
    input  wire  rst,
    input  wire  divE,
    output logic divStall
);

    localparam int CNT_W = $clog2(`DIV_LATENCY + 1);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(`DIV_LATENCY);

    logic [CNT_W-1:0] count;

    // stall until the divide has spent its full latency in Execute
    assign divStall = divE && (count != LAST);

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (!divE || count == LAST) begin
            // rearm for the next divide
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    countBound: assert property (@(posedge clk) disable iff (rst) count <= LAST)
        else $error("divider count past latency");

endmodule

`default_nettype wire

/* hdl/hazard.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pipeCtrl_settings.svh"

module hazard import pipeCtrlPkg::*; (
    input  wire [`REG_W-1:0] rsD,
    input  wire [`REG_W-1:0] rtD,
    input  wire              branchD,
    input  wire [`REG_W-1:0] rsE,
    input  wire [`REG_W-1:0] rtE,
    input  wire [`REG_W-1:0] writeRegE,
    input  wire              regWriteE,
    input  wire              memToRegE,
    input  wire              hiloReadE,
    input  wire [`REG_W-1:0] writeRegM,
    input  wire              regWriteM,
    input  wire              memToRegM,
    input  wire              hiloWriteM,
    input  wire [`REG_W-1:0] writeRegW,
    input  wire              regWriteW,
    input  wire              divStall,
    output fwdSel_t          forwardAE,
    output fwdSel_t          forwardBE,
    output logic             forwardAD,
    output logic             forwardBD,
    output logic             forwardHilo,
    output logic             stallF,
    output logic             stallD,
    output logic             flushE,
    output logic             stallE,
    output logic             stallM,
    output logic             stallW
);

    logic lwStall;
    logic branchStall;

    // Execute operands, newest result first, never register 0
    always_comb begin
        forwardAE = FWD_NONE;
        forwardBE = FWD_NONE;
        if (rsE != '0 && rsE == writeRegM && regWriteM) begin
            forwardAE = FWD_MEM;
        end else if (rsE != '0 && rsE == writeRegW && regWriteW) begin
            forwardAE = FWD_WB;
        end
        if (rtE != '0 && rtE == writeRegM && regWriteM) begin
            forwardBE = FWD_MEM;
        end else if (rtE != '0 && rtE == writeRegW && regWriteW) begin
            forwardBE = FWD_WB;
        end
    end

    // branch compare in Decode only sees the Memory result
    assign forwardAD   = (rsD != '0) && (rsD == writeRegM) && regWriteM;
    assign forwardBD   = (rtD != '0) && (rtD == writeRegM) && regWriteM;
    assign forwardHilo = hiloReadE && hiloWriteM;

    // rtD is already zero when rt is not a source
    assign lwStall = memToRegE &&
        ((rsD == writeRegE) || (rtD != '0 && rtD == writeRegE));

    assign branchStall = branchD &&
        ((regWriteE && (writeRegE == rsD || writeRegE == rtD)) ||
         (memToRegM && (writeRegM == rsD || writeRegM == rtD)));

    // a frozen Execute keeps its instruction, so no bubble then
    assign flushE = (lwStall || branchStall) && !divStall;
    assign stallF = lwStall || branchStall || divStall;
    assign stallD = lwStall || branchStall || divStall;
    assign stallE = divStall;
    assign stallM = divStall;
    assign stallW = divStall;

    always_comb begin
        flushWhileStalled: assert (!(flushE && stallE))
            else $error("Execute flushed and stalled together");
    end

endmodule

`default_nettype wire

/* hdl/instrDecode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pipeCtrl_settings.svh"

module instrDecode import pipeCtrlPkg::*; (
    input  wire [31:0]         instr,
    input  wire                instrValid,
    output logic [`REG_W-1:0]  rsD,
    output logic [`REG_W-1:0]  rtD,
    output logic [`REG_W-1:0]  writeRegD,
    output logic               regWriteD,
    output logic               memToRegD,
    output logic               branchD,
    output logic               hiloReadD,
    output logic               hiloWriteD,
    output logic               divD,
    output opClass_t           opClassD
);

    logic [5:0]        opcode;
    logic [5:0]        funct;
    logic [`REG_W-1:0] rs;
    logic [`REG_W-1:0] rt;
    logic [`REG_W-1:0] rd;
    logic              rsSrc;
    logic              rtSrc;

    assign opcode = instr[31:26];
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign funct  = instr[5:0];

    always_comb begin
        opClassD  = OP_NOP;
        rsSrc     = 1'b0;
        rtSrc     = 1'b0;
        writeRegD = '0;
        regWriteD = 1'b0;
        // all-zero word is the canonical nop
        if (instrValid && instr != 32'd0) begin
            case (opcode)
                6'h00: begin
                    case (funct)
                        6'h08: begin
                            opClassD = OP_JUMP;
                            rsSrc    = 1'b1;
                        end
                        6'h09: begin
                            opClassD  = OP_JUMP;
                            rsSrc     = 1'b1;
                            writeRegD = rd;
                            regWriteD = 1'b1;
                        end
                        6'h10, 6'h12: begin
                            opClassD  = OP_MFHILO;
                            writeRegD = rd;
                            regWriteD = 1'b1;
                        end
                        6'h11, 6'h13: begin
                            opClassD = OP_MTHILO;
                            rsSrc    = 1'b1;
                        end
                        6'h1a, 6'h1b: begin
                            opClassD = OP_DIV;
                            rsSrc    = 1'b1;
                            rtSrc    = 1'b1;
                        end
                        default: begin
                            opClassD  = OP_ALU;
                            rsSrc     = 1'b1;
                            rtSrc     = 1'b1;
                            writeRegD = rd;
                            regWriteD = 1'b1;
                        end
                    endcase
                end
                // rt selects the condition here, not a register
                6'h01: begin
                    opClassD = OP_REGIMM;
                    rsSrc    = 1'b1;
                    if (rt[4]) begin
                        writeRegD = `REG_W'd31;
                        regWriteD = 1'b1;
                    end
                end
                6'h02: opClassD = OP_JUMP;
                6'h03: begin
                    opClassD  = OP_JUMP;
                    writeRegD = `REG_W'd31;
                    regWriteD = 1'b1;
                end
                6'h04, 6'h05: begin
                    opClassD = OP_BRANCH;
                    rsSrc    = 1'b1;
                    rtSrc    = 1'b1;
                end
                6'h06, 6'h07: begin
                    opClassD = OP_BRANCH;
                    rsSrc    = 1'b1;
                end
                6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f: begin
                    opClassD  = OP_ALU;
                    // lui has no source register
                    rsSrc     = (opcode != 6'h0f);
                    writeRegD = rt;
                    regWriteD = 1'b1;
                end
                6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25: begin
                    opClassD  = OP_LOAD;
                    rsSrc     = 1'b1;
                    writeRegD = rt;
                    regWriteD = 1'b1;
                end
                6'h28, 6'h29, 6'h2b: begin
                    opClassD = OP_STORE;
                    rsSrc    = 1'b1;
                    rtSrc    = 1'b1;
                end
                default: opClassD = OP_NOP;
            endcase
        end
        rsD = rsSrc ? rs : '0;
        rtD = rtSrc ? rt : '0;
    end

    assign memToRegD  = (opClassD == OP_LOAD);
    assign branchD    = (opClassD == OP_BRANCH) || (opClassD == OP_REGIMM);
    assign hiloReadD  = (opClassD == OP_MFHILO);
    assign hiloWriteD = (opClassD == OP_MTHILO) || (opClassD == OP_DIV);
    assign divD       = (opClassD == OP_DIV);

endmodule

`default_nettype wire

/* hdl/pipeCtrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pipeCtrl_settings.svh"

module pipeCtrl import pipeCtrlPkg::*; (
    input  wire                clk,
    input  wire                rst,
    input  wire [31:0]         instr,
    input  wire                instrValid,
    output fwdSel_t            forwardAE,
    output fwdSel_t            forwardBE,
    output logic               forwardAD,
    output logic               forwardBD,
    output logic               forwardHilo,
    output logic               stallF,
    output logic               stallD,
    output logic               flushE,
    output logic               stallE,
    output logic               stallM,
    output logic               stallW,
    output logic [`REG_W-1:0]  writeRegW,
    output logic               regWriteW
);

    // decode stage
    logic [`REG_W-1:0] rsD;
    logic [`REG_W-1:0] rtD;
    logic [`REG_W-1:0] writeRegD;
    logic              regWriteD;
    logic              memToRegD;
    logic              branchD;
    logic              hiloReadD;
    logic              hiloWriteD;
    logic              divD;
    opClass_t          opClassD;

    // execute and memory stages
    logic [`REG_W-1:0] rsE;
    logic [`REG_W-1:0] rtE;
    logic [`REG_W-1:0] writeRegE;
    logic              regWriteE;
    logic              memToRegE;
    logic              hiloReadE;
    logic              divE;
    logic [`REG_W-1:0] writeRegM;
    logic              regWriteM;
    logic              memToRegM;
    logic              hiloWriteM;
    logic              divStall;

    instrDecode instrDecode_i (
        .instr      (instr),
        .instrValid (instrValid),
        .rsD        (rsD),
        .rtD        (rtD),
        .writeRegD  (writeRegD),
        .regWriteD  (regWriteD),
        .memToRegD  (memToRegD),
        .branchD    (branchD),
        .hiloReadD  (hiloReadD),
        .hiloWriteD (hiloWriteD),
        .divD       (divD),
        .opClassD   (opClassD)
    );

    stageTrack stageTrack_i (
        .clk        (clk),
        .rst        (rst),
        .rsD        (rsD),
        .rtD        (rtD),
        .writeRegD  (writeRegD),
        .regWriteD  (regWriteD),
        .memToRegD  (memToRegD),
        .hiloReadD  (hiloReadD),
        .hiloWriteD (hiloWriteD),
        .divD       (divD),
        .opClassD   (opClassD),
        .stallE     (stallE),
        .stallM     (stallM),
        .stallW     (stallW),
        .flushE     (flushE),
        .rsE        (rsE),
        .rtE        (rtE),
        .writeRegE  (writeRegE),
        .regWriteE  (regWriteE),
        .memToRegE  (memToRegE),
        .hiloReadE  (hiloReadE),
        .divE       (divE),
        .writeRegM  (writeRegM),
        .regWriteM  (regWriteM),
        .memToRegM  (memToRegM),
        .hiloWriteM (hiloWriteM),
        .writeRegW  (writeRegW),
        .regWriteW  (regWriteW)
    );

    divTimer divTimer_i (
        .clk      (clk),
        .rst      (rst),
        .divE     (divE),
        .divStall (divStall)
    );

    hazard hazard_i (
        .rsD         (rsD),
        .rtD         (rtD),
        .branchD     (branchD),
        .rsE         (rsE),
        .rtE         (rtE),
        .writeRegE   (writeRegE),
        .regWriteE   (regWriteE),
        .memToRegE   (memToRegE),
        .hiloReadE   (hiloReadE),
        .writeRegM   (writeRegM),
        .regWriteM   (regWriteM),
        .memToRegM   (memToRegM),
        .hiloWriteM  (hiloWriteM),
        .writeRegW   (writeRegW),
        .regWriteW   (regWriteW),
        .divStall    (divStall),
        .forwardAE   (forwardAE),
        .forwardBE   (forwardBE),
        .forwardAD   (forwardAD),
        .forwardBD   (forwardBD),
        .forwardHilo (forwardHilo),
        .stallF      (stallF),
        .stallD      (stallD),
        .flushE      (flushE),
        .stallE      (stallE),
        .stallM      (stallM),
        .stallW      (stallW)
    );

endmodule

`default_nettype wire

/* hdl/pipeCtrlPkg.sv */
`default_nettype none

`include "pipeCtrl_settings.svh"

package pipeCtrlPkg;

    // instruction class seen by the hazard logic
    typedef enum logic [3:0] {
        OP_NOP    = 4'd0,
        OP_ALU    = 4'd1,
        OP_LOAD   = 4'd2,
        OP_STORE  = 4'd3,
        OP_BRANCH = 4'd4,
        OP_REGIMM = 4'd5,
        OP_JUMP   = 4'd6,
        OP_MFHILO = 4'd7,
        OP_MTHILO = 4'd8,
        OP_DIV    = 4'd9
    } opClass_t;

    // Execute operand source, memory result is the newest
    typedef enum logic [1:0] {
        FWD_NONE = 2'b00,
        FWD_WB   = 2'b01,
        FWD_MEM  = 2'b10
    } fwdSel_t;

    // contents of one pipeline stage register
    typedef struct packed {
        logic              valid;
        logic [`REG_W-1:0] rs;
        logic [`REG_W-1:0] rt;
        logic [`REG_W-1:0] writeReg;
        logic              regWrite;
        logic              memToReg;
        logic              hiloRead;
        logic              hiloWrite;
        opClass_t          opClass;
    } stageFields_t;

endpackage

`default_nettype wire

/* hdl/pipeCtrl_settings.svh */
`ifndef PIPECTRL_SETTINGS_SVH
`define PIPECTRL_SETTINGS_SVH

// register index width, 32 registers
`define REG_W 5

// cycles a divide occupies Execute
`define DIV_LATENCY 8

`endif

/* hdl/stageTrack.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pipeCtrl_settings.svh"

module stageTrack import pipeCtrlPkg::*; (
    input  wire                clk,
    input  wire                rst,
    input  wire [`REG_W-1:0]   rsD,
    input  wire [`REG_W-1:0]   rtD,
    input  wire [`REG_W-1:0]   writeRegD,
    input  wire                regWriteD,
    input  wire                memToRegD,
    input  wire                hiloReadD,
    input  wire                hiloWriteD,
    input  wire                divD,
    input  wire opClass_t      opClassD,
    input  wire                stallE,
    input  wire                stallM,
    input  wire                stallW,
    input  wire                flushE,
    output logic [`REG_W-1:0]  rsE,
    output logic [`REG_W-1:0]  rtE,
    output logic [`REG_W-1:0]  writeRegE,
    output logic               regWriteE,
    output logic               memToRegE,
    output logic               hiloReadE,
    output logic               divE,
    output logic [`REG_W-1:0]  writeRegM,
    output logic               regWriteM,
    output logic               memToRegM,
    output logic               hiloWriteM,
    output logic [`REG_W-1:0]  writeRegW,
    output logic               regWriteW
);

    stageFields_t decRec;
    stageFields_t exReg;
    stageFields_t memReg;
    stageFields_t wbReg;
    logic         divReg;

    always_comb begin
        decRec.valid     = (opClassD != OP_NOP);
        decRec.rs        = rsD;
        decRec.rt        = rtD;
        decRec.writeReg  = writeRegD;
        decRec.regWrite  = regWriteD;
        decRec.memToReg  = memToRegD;
        decRec.hiloRead  = hiloReadD;
        decRec.hiloWrite = hiloWriteD;
        decRec.opClass   = opClassD;
    end

    // all-zero record is a bubble
    always_ff @(posedge clk) begin
        if (rst) begin
            exReg  <= '0;
            memReg <= '0;
            wbReg  <= '0;
            divReg <= 1'b0;
        end else begin
            if (!stallW) begin
                wbReg <= memReg;
            end
            if (!stallM) begin
                memReg <= exReg;
            end
            if (flushE && !stallE) begin
                exReg  <= '0;
                divReg <= 1'b0;
            end else if (!stallE) begin
                exReg  <= decRec;
                divReg <= divD;
            end
        end
    end

    assign rsE        = exReg.rs;
    assign rtE        = exReg.rt;
    assign writeRegE  = exReg.writeReg;
    assign regWriteE  = exReg.regWrite;
    assign memToRegE  = exReg.memToReg;
    assign hiloReadE  = exReg.hiloRead;
    assign divE       = divReg;
    assign writeRegM  = memReg.writeReg;
    assign regWriteM  = memReg.regWrite;
    assign memToRegM  = memReg.memToReg;
    assign hiloWriteM = memReg.hiloWrite;
    // writeback destination is what the subsystem presents outward
    assign writeRegW  = wbReg.writeReg;
    assign regWriteW  = wbReg.regWrite;

    hiloWriteValid: assert property (@(posedge clk) disable iff (rst)
        memReg.hiloWrite |-> memReg.valid)
        else $error("HI/LO write in Memory without a valid instruction");

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module tbPipeCtrl -o simPipeCtrl

out=$(./obj_dir/simPipeCtrl 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "sim passed"; then
    exit 0
else
    exit 1
fi

/* testbench/clockGen.sv */
`timescale 1ns/1ps
`default_nettype none

module clockGen (
    output logic clk,
    output logic rst
);

    localparam time HALF_PERIOD = 50ns;
    localparam int  RESET_CYCLES = 5;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // release on a falling edge, like every other driven input
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

/* testbench/tbPipeCtrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pipeCtrl_settings.svh"

module tbPipeCtrl import pipeCtrlPkg::*; ();

    localparam logic [31:0] SEED = 32'h05b2_5034;
    localparam int NUM_INSTR   = 400;
    localparam int MAX_CYCLES  = 8000;
    localparam int DRAIN_LIMIT = 100;
    localparam int RESET_LIMIT = 20;

    // one stage of the reference pipeline
    typedef struct packed {
        logic              valid;
        logic [`REG_W-1:0] rs;
        logic [`REG_W-1:0] rt;
        logic [`REG_W-1:0] wr;
        logic              rw;
        logic              m2r;
        logic              hr;
        logic              hw;
        logic              isDiv;
        logic              br;
    } modelRec_t;

    logic              clk;
    logic              rst;
    logic [31:0]       instr;
    logic              instrValid;
    fwdSel_t           forwardAE;
    fwdSel_t           forwardBE;
    logic              forwardAD;
    logic              forwardBD;
    logic              forwardHilo;
    logic              stallF;
    logic              stallD;
    logic              flushE;
    logic              stallE;
    logic              stallM;
    logic              stallW;
    logic [`REG_W-1:0] writeRegW;
    logic              regWriteW;

    logic [31:0]       lfsr;
    modelRec_t         mD;
    modelRec_t         mE;
    modelRec_t         mM;
    modelRec_t         mW;
    int                mCount;
    fwdSel_t           expAE;
    fwdSel_t           expBE;
    logic              expAD;
    logic              expBD;
    logic              expHilo;
    logic              expStallF;
    logic              expStallE;
    logic              expFlushE;
    logic              prevStallF;
    logic              wFresh;
    int                sent;
    int                cycles;
    int                stallRun;
    int                resetWait;
    logic [`REG_W-1:0] wrQueue[$];

    clockGen clockGen_i (
        .clk (clk),
        .rst (rst)
    );

    pipeCtrl pipeCtrl_i (
        .clk         (clk),
        .rst         (rst),
        .instr       (instr),
        .instrValid  (instrValid),
        .forwardAE   (forwardAE),
        .forwardBE   (forwardBE),
        .forwardAD   (forwardAD),
        .forwardBD   (forwardBD),
        .forwardHilo (forwardHilo),
        .stallF      (stallF),
        .stallD      (stallD),
        .flushE      (flushE),
        .stallE      (stallE),
        .stallM      (stallM),
        .stallW      (stallW),
        .writeRegW   (writeRegW),
        .regWriteW   (regWriteW)
    );

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1, "run aborted");
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s expected %0h got %0h",
                     $time, name, expected, actual);
            $display("sim failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic drawBits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrNext(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    // register indices 0..3 keep hazards frequent
    task automatic genInstr();
        logic [31:0]       pick;
        logic [31:0]       ra;
        logic [31:0]       rb;
        logic [31:0]       rc;
        logic [31:0]       lnk;
        logic [`REG_W-1:0] rs;
        logic [`REG_W-1:0] rt;
        logic [`REG_W-1:0] rd;
        drawBits(4, pick);
        drawBits(2, ra);
        drawBits(2, rb);
        drawBits(2, rc);
        rs = {3'b000, ra[1:0]};
        rt = {3'b000, rb[1:0]};
        rd = {3'b000, rc[1:0]};
        instrValid = 1'b1;
        mD = '0;
        mD.valid = 1'b1;
        case (pick[3:0])
            4'd0, 4'd1, 4'd2: begin
                instr = {6'h23, rs, rt, 16'h0010};
                mD.rs = rs;
                mD.wr = rt;
                mD.rw = 1'b1;
                mD.m2r = 1'b1;
            end
            4'd3, 4'd4: begin
                instr = {6'h04, rs, rt, 16'h0004};
                mD.rs = rs;
                mD.rt = rt;
                mD.br = 1'b1;
            end
            4'd5: begin
                // rt field is a condition code, the link form writes r31
                drawBits(1, lnk);
                instr = {6'h01, rs, lnk[0], 2'b00, rb[1:0], 16'h0004};
                mD.rs = rs;
                mD.br = 1'b1;
                mD.rw = lnk[0];
                mD.wr = lnk[0] ? 5'd31 : 5'd0;
            end
            4'd6, 4'd14: begin
                instr = {6'h00, 5'd0, 5'd0, rd, 5'd0, 6'h10};
                mD.wr = rd;
                mD.rw = 1'b1;
                mD.hr = 1'b1;
            end
            4'd7: begin
                instr = {6'h00, rs, 5'd0, 5'd0, 5'd0, 6'h11};
                mD.rs = rs;
                mD.hw = 1'b1;
            end
            4'd8: begin
                instr = {6'h00, rs, rt, 5'd0, 5'd0, 6'h1a};
                mD.rs = rs;
                mD.rt = rt;
                mD.hw = 1'b1;
                mD.isDiv = 1'b1;
            end
            4'd9, 4'd10: begin
                instr = {6'h00, rs, rt, rd, 5'd0, 6'h20};
                mD.rs = rs;
                mD.rt = rt;
                mD.wr = rd;
                mD.rw = 1'b1;
            end
            4'd11: begin
                instr = {6'h08, rs, rt, 16'h0010};
                mD.rs = rs;
                mD.wr = rt;
                mD.rw = 1'b1;
            end
            4'd12: begin
                instr = {6'h2b, rs, rt, 16'h0008};
                mD.rs = rs;
                mD.rt = rt;
            end
            4'd13: begin
                instr = {6'h03, 26'h0000040};
                mD.wr = 5'd31;
                mD.rw = 1'b1;
            end
            default: begin
                // a load word that must be ignored
                instrValid = 1'b0;
                instr = {6'h23, rs, rt, 16'h0000};
                mD = '0;
            end
        endcase
    endtask

    task automatic predict();
        logic lwStall;
        logic brStall;
        logic divStall;
        expAE = FWD_NONE;
        expBE = FWD_NONE;
        if (mE.rs != 5'd0 && mE.rs == mM.wr && mM.rw) begin
            expAE = FWD_MEM;
        end else if (mE.rs != 5'd0 && mE.rs == mW.wr && mW.rw) begin
            expAE = FWD_WB;
        end
        if (mE.rt != 5'd0 && mE.rt == mM.wr && mM.rw) begin
            expBE = FWD_MEM;
        end else if (mE.rt != 5'd0 && mE.rt == mW.wr && mW.rw) begin
            expBE = FWD_WB;
        end
        expAD = (mD.rs != 5'd0) && (mD.rs == mM.wr) && mM.rw;
        expBD = (mD.rt != 5'd0) && (mD.rt == mM.wr) && mM.rw;
        expHilo = mE.hr && mM.hw;
        lwStall = mE.m2r && ((mD.rs == mE.wr) || (mD.rt != 5'd0 && mD.rt == mE.wr));
        brStall = mD.br &&
            ((mE.rw && (mE.wr == mD.rs || mE.wr == mD.rt)) ||
             (mM.m2r && (mM.wr == mD.rs || mM.wr == mD.rt)));
        divStall = mE.valid && mE.isDiv && (mCount != `DIV_LATENCY);
        expStallE = divStall;
        expStallF = lwStall || brStall || divStall;
        // Execute frozen by the divider keeps its instruction
        expFlushE = (lwStall || brStall) && !divStall;
    endtask

    task automatic compareOutputs();
        logic [`REG_W-1:0] expWr;
        check("forwardAE", 32'(forwardAE), 32'(expAE));
        check("forwardBE", 32'(forwardBE), 32'(expBE));
        check("forwardAD", 32'(forwardAD), 32'(expAD));
        check("forwardBD", 32'(forwardBD), 32'(expBD));
        check("forwardHilo", 32'(forwardHilo), 32'(expHilo));
        check("stallF", 32'(stallF), 32'(expStallF));
        check("stallD", 32'(stallD), 32'(expStallF));
        check("flushE", 32'(flushE), 32'(expFlushE));
        check("stallE", 32'(stallE), 32'(expStallE));
        check("stallM", 32'(stallM), 32'(expStallE));
        check("stallW", 32'(stallW), 32'(expStallE));
        check("regWriteW", 32'(regWriteW), 32'(mW.rw));
        check("writeRegW", 32'(writeRegW), 32'(mW.wr));
        // program-order write stream, counted once per Writeback load
        if (wFresh && regWriteW) begin
            if (wrQueue.size() == 0) begin
                abortRun("a register write retired that was never issued");
            end else begin
                expWr = wrQueue.pop_front();
                check("writeRegW stream", 32'(writeRegW), 32'(expWr));
            end
        end
        if (stallE) begin
            stallRun++;
        end else begin
            if (stallRun != 0) begin
                check("divide stall length", 32'(stallRun), 32'(`DIV_LATENCY));
            end
            stallRun = 0;
        end
    endtask

    task automatic advanceModel();
        logic divE;
        wFresh = !expStallE;
        if (!expStallF && mD.rw) begin
            wrQueue.push_back(mD.wr);
        end
        divE = mE.valid && mE.isDiv;
        if (!divE || mCount == `DIV_LATENCY) begin
            mCount = 0;
        end else begin
            mCount++;
        end
        if (!expStallE) begin
            mW = mM;
            mM = mE;
        end
        if (expFlushE && !expStallE) begin
            mE = '0;
        end else if (!expStallE) begin
            mE = mD;
        end
    endtask

    // drive on the falling edge, sample 10 ns later
    task automatic stepCycle(input logic newAllowed);
        if (!prevStallF) begin
            if (newAllowed) begin
                genInstr();
                sent++;
            end else begin
                instr = 32'h8c22_0000;
                instrValid = 1'b0;
                mD = '0;
            end
        end
        #10;
        predict();
        compareOutputs();
        advanceModel();
        prevStallF = expStallF;
        @(negedge clk);
    endtask

    initial begin
        instr = 32'd0;
        instrValid = 1'b0;
        lfsr = SEED;
        mD = '0;
        mE = '0;
        mM = '0;
        mW = '0;
        mCount = 0;
        prevStallF = 1'b0;
        wFresh = 1'b0;
        sent = 0;
        cycles = 0;
        stallRun = 0;
        resetWait = 0;

        // reset changes on a falling edge, so look at it on the rising one
        @(posedge clk);
        while (rst !== 1'b0) begin
            resetWait++;
            if (resetWait > RESET_LIMIT) abortRun("timeout waiting for reset release");
            @(posedge clk);
        end

        // bubbles everywhere right after reset
        #10;
        check("stallF after reset", 32'(stallF), 32'd0);
        check("stallD after reset", 32'(stallD), 32'd0);
        check("flushE after reset", 32'(flushE), 32'd0);
        check("stallE after reset", 32'(stallE), 32'd0);
        check("stallM after reset", 32'(stallM), 32'd0);
        check("stallW after reset", 32'(stallW), 32'd0);
        check("forwardAE after reset", 32'(forwardAE), 32'(FWD_NONE));
        check("forwardBE after reset", 32'(forwardBE), 32'(FWD_NONE));
        check("forwardAD after reset", 32'(forwardAD), 32'd0);
        check("forwardBD after reset", 32'(forwardBD), 32'd0);
        check("forwardHilo after reset", 32'(forwardHilo), 32'd0);
        check("regWriteW after reset", 32'(regWriteW), 32'd0);
        @(negedge clk);

        while (sent < NUM_INSTR) begin
            if (cycles > MAX_CYCLES) abortRun("timeout while sending instructions");
            stepCycle(1'b1);
            cycles++;
        end

        cycles = 0;
        while (prevStallF || mE.valid || mM.valid || mW.valid || wrQueue.size() != 0) begin
            if (cycles > DRAIN_LIMIT) abortRun("timeout waiting for the pipeline to drain");
            stepCycle(1'b0);
            cycles++;
        end

        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire
